//--- design/dac_cfg.svh
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// cell population of the segmented array
`define DAC_NUM_CELLS    24 // redundant lsb + 6 binary + 17 thermometer
`define DAC_FIRST_THERM  7  // cells below this index are binary weighted

// input word field widths
`define DAC_BIN_W        6  // binary steering bits
`define DAC_THERM_W      17 // thermometer steering bits
`define DAC_CAL_W        5  // calibration cell select

// output field widths
`define DAC_SUM_W        11 // full scale is 1152 lsb units
`define DAC_FAULT_W      5  // enough for all 24 cells

// weight of one thermometer cell in lsb units
`define DAC_THERM_UNITS  64

`endif

//--- design/dacPkg.sv
`default_nettype none

`include "dac_cfg.svh"

package dacPkg;

    typedef struct packed {
        logic [`DAC_BIN_W-1:0]   bin;    // binary steering, true side
        logic [`DAC_BIN_W-1:0]   binB;   // binary steering, complement side
        logic [`DAC_THERM_W-1:0] therm;  // thermometer steering, true side
        logic [`DAC_THERM_W-1:0] thermB; // thermometer steering, complement side
        logic [`DAC_CAL_W-1:0]   calSel; // cell routed to iCal, 0 for none
        logic                    pdb;    // power down, active low
    } dacIn_t;

    typedef struct packed {
        logic data;      // true switch
        logic dataB;     // complement switch
        logic calibrate; // cell goes to the calibration output
        logic enable;    // cell powered
    } cellCtrl_t;

    typedef struct packed {
        logic [`DAC_SUM_W-1:0] posUnits; // share of iOut
        logic [`DAC_SUM_W-1:0] negUnits; // share of iOutB
        logic [`DAC_SUM_W-1:0] calUnits; // share of iCal
        logic                  fault;    // switch pair not complementary
        logic                  active;   // cell was enabled
    } cellOut_t;

    typedef struct packed {
        logic [`DAC_SUM_W-1:0]   iOut;
        logic [`DAC_SUM_W-1:0]   iOutB;
        logic [`DAC_SUM_W-1:0]   iCal;
        logic                    outValid;
        logic                    calValid;
        logic [`DAC_FAULT_W-1:0] faultCount;
    } dacOut_t;

    // cells 0 and 1 carry one unit each, then powers of two, then the unary segment
    function automatic logic [`DAC_SUM_W-1:0] cellWeight(input int idx);
        logic [`DAC_SUM_W-1:0] w;
        if (idx < 2) begin
            w = `DAC_SUM_W'(1);
        end else if (idx < `DAC_FIRST_THERM) begin
            w = `DAC_SUM_W'(1) << (idx - 1); // 2, 4, 8, 16, 32
        end else begin
            w = `DAC_SUM_W'(`DAC_THERM_UNITS);
        end
        return w;
    endfunction

endpackage

`default_nettype wire

//--- design/steerDecoder.sv
`default_nettype none

`include "dac_cfg.svh"

module steerDecoder (
    input  logic              clk,
    input  logic              arstN,
    input  dacPkg::dacIn_t    dacIn,
    output dacPkg::cellCtrl_t cellCtrl [`DAC_NUM_CELLS]
);
    import dacPkg::*;

    dacIn_t                    inReg;  // sampled input word
    logic [`DAC_NUM_CELLS-1:0] calHit; // one-hot calibration select

    // first pipeline stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inReg <= '0;
        end else begin
            inReg <= dacIn;
        end
    end

    // code 0 and codes past the last cell select nothing
    always_comb begin
        calHit = '0;
        if (inReg.calSel != '0 && inReg.calSel < `DAC_CAL_W'(`DAC_NUM_CELLS)) begin
            calHit[inReg.calSel] = 1'b1;
        end
    end

    // place every bit pair on its cell position
    for (genvar k = 0; k < `DAC_NUM_CELLS; k++) begin : cellMap
        logic bitTrue;
        logic bitComp;

        if (k < 2) begin : lsbPair
            // redundant lsb and binary lsb share bit 0
            assign bitTrue = inReg.bin[0];
            assign bitComp = inReg.binB[0];
        end else if (k < `DAC_FIRST_THERM) begin : binPair
            assign bitTrue = inReg.bin[k-1];
            assign bitComp = inReg.binB[k-1];
        end else begin : thermPair
            assign bitTrue = inReg.therm[k-`DAC_FIRST_THERM];
            assign bitComp = inReg.thermB[k-`DAC_FIRST_THERM];
        end

        assign cellCtrl[k] = '{
            data:      bitTrue,
            dataB:     bitComp,
            calibrate: calHit[k],
            enable:    inReg.pdb // power down reaches every cell at once
        };
    end

endmodule

`default_nettype wire

//--- design/currentCell.sv
`default_nettype none

`include "dac_cfg.svh"

module currentCell #(
    parameter int cellIdx = 0
) (
    input  logic              clk,
    input  logic              arstN,
    input  dacPkg::cellCtrl_t ctrl,
    output dacPkg::cellOut_t  cellOut
);
    import dacPkg::*;

    localparam logic [`DAC_SUM_W-1:0] Weight = cellWeight(cellIdx);

    logic     pairOk;  // exactly one switch closed
    cellOut_t nextOut;

    assign pairOk = ctrl.data ^ ctrl.dataB;

    always_comb begin
        nextOut = '0; // powered down cell sources nothing
        if (ctrl.enable) begin
            nextOut.active = 1'b1;
            if (ctrl.calibrate) begin
                nextOut.calUnits = Weight; // steering pair is don't care here
            end else if (pairOk) begin
                if (ctrl.data) begin
                    nextOut.posUnits = Weight;
                end else begin
                    nextOut.negUnits = Weight;
                end
            end else begin
                // both switches open or both closed, current is lost
                nextOut.fault = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cellOut <= '0;
        end else begin
            cellOut <= nextOut;
        end
    end

endmodule

`default_nettype wire

//--- design/outputCombiner.sv
`default_nettype none

`include "dac_cfg.svh"

module outputCombiner (
    input  logic             clk,
    input  logic             arstN,
    input  dacPkg::cellOut_t cellOut [`DAC_NUM_CELLS],
    output dacPkg::dacOut_t  dacOut
);
    import dacPkg::*;

    logic [`DAC_SUM_W-1:0]   posSum;
    logic [`DAC_SUM_W-1:0]   negSum;
    logic [`DAC_SUM_W-1:0]   calSum;
    logic [`DAC_FAULT_W-1:0] faultSum;
    logic                    anyActive;
    logic                    anyCal;
    dacOut_t                 nextOut;

    // full scale of 1152 fits the sum width, no overflow possible
    always_comb begin
        posSum    = '0;
        negSum    = '0;
        calSum    = '0;
        faultSum  = '0;
        anyActive = 1'b0;
        anyCal    = 1'b0;
        for (int k = 0; k < `DAC_NUM_CELLS; k++) begin
            posSum    = posSum + cellOut[k].posUnits;
            negSum    = negSum + cellOut[k].negUnits;
            calSum    = calSum + cellOut[k].calUnits;
            faultSum  = faultSum + `DAC_FAULT_W'(cellOut[k].fault);
            anyActive = anyActive | cellOut[k].active;
            // only a calibrated cell puts units on iCal
            anyCal    = anyCal | (cellOut[k].calUnits != '0);
        end
    end

    always_comb begin
        nextOut            = '0;
        nextOut.iOut       = posSum;
        nextOut.iOutB      = negSum;
        nextOut.iCal       = calSum;
        nextOut.outValid   = anyActive;
        nextOut.calValid   = anyCal;
        nextOut.faultCount = faultSum;
    end

    // last pipeline stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacOut <= '0;
        end else begin
            dacOut <= nextOut;
        end
    end

endmodule

`default_nettype wire

//--- design/currentSteeringDac.sv
`default_nettype none

`include "dac_cfg.svh"

module currentSteeringDac (
    input  logic            clk,
    input  logic            arstN,
    input  dacPkg::dacIn_t  dacIn,
    output dacPkg::dacOut_t dacOut
);
    import dacPkg::*;

    cellCtrl_t cellCtrl [`DAC_NUM_CELLS]; // decoder to cells
    cellOut_t  cellOut  [`DAC_NUM_CELLS]; // cells to combiner

    steerDecoder uDecoder (
        .clk      (clk),
        .arstN    (arstN),
        .dacIn    (dacIn),
        .cellCtrl (cellCtrl)
    );

    // each cell knows its own weight from its position
    for (genvar k = 0; k < `DAC_NUM_CELLS; k++) begin : cellArray
        currentCell #(
            .cellIdx (k)
        ) uCell (
            .clk     (clk),
            .arstN   (arstN),
            .ctrl    (cellCtrl[k]),
            .cellOut (cellOut[k])
        );
    end

    outputCombiner uCombiner (
        .clk     (clk),
        .arstN   (arstN),
        .cellOut (cellOut),
        .dacOut  (dacOut)
    );

endmodule

`default_nettype wire

//--- dv/dac_props.sv
`default_nettype none

`include "dac_cfg.svh"

module dacProps (
    input logic            clk,
    input logic            arstN,
    input dacPkg::dacOut_t dacOut
);
    timeunit 1ns;
    timeprecision 1ps;

    // 17 thermometer cells plus the binary segment with its redundant lsb
    localparam int FullScale = `DAC_THERM_W * `DAC_THERM_UNITS + (1 << `DAC_BIN_W);

    idleIsZero: assert property (@(posedge clk) disable iff (!arstN)
        !dacOut.outValid |-> (dacOut.iOut == '0 && dacOut.iOutB == '0
                              && dacOut.iCal == '0 && dacOut.faultCount == '0))
        else $error("outputs carry current or faults while outValid is low");

    sumInRange: assert property (@(posedge clk) disable iff (!arstN)
        int'(dacOut.iOut) + int'(dacOut.iOutB) + int'(dacOut.iCal) <= FullScale)
        else $error("iOut + iOutB + iCal exceeds full scale");

    calNeedsOut: assert property (@(posedge clk) disable iff (!arstN)
        dacOut.calValid |-> dacOut.outValid)
        else $error("calValid high while outValid is low");

endmodule

`default_nettype wire

//--- dv/dacChecker.sv
`default_nettype none

`include "dac_cfg.svh"

module dacChecker (
    input  logic            clk,
    input  logic            arstN,
    input  dacPkg::dacIn_t  dacIn,
    input  dacPkg::dacOut_t dacOut,
    output int              checkCount,
    output int              errorCount
);
    timeunit 1ns;
    timeprecision 1ps;

    import dacPkg::*;

    // redundant lsb, binary lsb, then the binary cells up to 32 units
    localparam int BinUnits [`DAC_FIRST_THERM] = '{1, 1, 2, 4, 8, 16, 32};

    dacIn_t hist0; // newest sampled input
    dacIn_t hist1;
    dacIn_t hist2; // the one now at the outputs
    int     checks = 0;
    int     errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    // expected output word for one input, straight from the cell rules
    function automatic dacOut_t expectedOut(input dacIn_t v);
        dacOut_t                   e;
        logic [`DAC_NUM_CELLS-1:0] trueVec;
        logic [`DAC_NUM_CELLS-1:0] compVec;
        int                        w;
        int                        pos;
        int                        neg;
        int                        cal;
        int                        faults;
        e      = '0;
        pos    = 0;
        neg    = 0;
        cal    = 0;
        faults = 0;
        // cell 0 at the lsb, bit 0 feeds both lsb cells
        trueVec = {v.therm, v.bin[`DAC_BIN_W-1:1], v.bin[0], v.bin[0]};
        compVec = {v.thermB, v.binB[`DAC_BIN_W-1:1], v.binB[0], v.binB[0]};
        if (v.pdb) begin
            for (int k = 0; k < `DAC_NUM_CELLS; k++) begin
                if (k < `DAC_FIRST_THERM) begin
                    w = BinUnits[k];
                end else begin
                    w = `DAC_THERM_UNITS;
                end
                if (k != 0 && k == int'(v.calSel)) begin
                    cal = cal + w;
                end else if (trueVec[0] == compVec[0]) begin
                    faults = faults + 1;
                end else if (trueVec[0]) begin
                    pos = pos + w;
                end else begin
                    neg = neg + w;
                end
                trueVec = trueVec >> 1;
                compVec = compVec >> 1;
            end
            e.outValid = 1'b1;
            e.calValid = (cal != 0);
        end
        e.iOut       = `DAC_SUM_W'(pos);
        e.iOutB      = `DAC_SUM_W'(neg);
        e.iCal       = `DAC_SUM_W'(cal);
        e.faultCount = `DAC_FAULT_W'(faults);
        return e;
    endfunction

    task automatic checkField(input string name, input int got, input int want);
        if (got != want) begin
            errors = errors + 1;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic compareOut(input dacOut_t want);
        checks = checks + 1;
        checkField("iOut", int'(dacOut.iOut), int'(want.iOut));
        checkField("iOutB", int'(dacOut.iOutB), int'(want.iOutB));
        checkField("iCal", int'(dacOut.iCal), int'(want.iCal));
        checkField("outValid", int'(dacOut.outValid), int'(want.outValid));
        checkField("calValid", int'(dacOut.calValid), int'(want.calValid));
        checkField("faultCount", int'(dacOut.faultCount), int'(want.faultCount));
    endtask

    // outputs and inputs are both settled half a cycle after the edge
    always @(negedge clk) begin
        if (!arstN) begin
            compareOut('0);
            hist0 <= '0;
            hist1 <= '0;
            hist2 <= '0;
        end else begin
            compareOut(expectedOut(hist2)); // three register stages behind
            hist2 <= hist1;
            hist1 <= hist0;
            hist0 <= dacIn; // sampled by the DUT at the next edge
        end
    end

endmodule

`default_nettype wire

//--- dv/dacTb.sv
`default_nettype none

`include "dac_cfg.svh"

module dacTb;
    timeunit 1ns;
    timeprecision 1ps;

    import dacPkg::*;

    localparam int NumSteer      = 400;
    localparam int NumCalRounds  = 6;    // vectors per calibration code
    localparam int NumFault      = 350;
    localparam int NumPdRandom   = 100;
    localparam int NumPdBlocks   = 10;   // 10 cycles each
    localparam int TimeoutCycles = 1400; // the run needs about 1160 cycles

    logic        clk;
    logic        arstN;
    dacIn_t      dacIn;
    dacOut_t     dacOut;
    logic [31:0] lfsr;
    int          cycleCount = 0;
    int          checkCount;
    int          errorCount;
    logic        endReached;

    currentSteeringDac DUT (
        .clk    (clk),
        .arstN  (arstN),
        .dacIn  (dacIn),
        .dacOut (dacOut)
    );

    dacChecker uChecker (
        .clk        (clk),
        .arstN      (arstN),
        .dacIn      (dacIn),
        .dacOut     (dacOut),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    bind outputCombiner dacProps uProps (
        .clk    (clk),
        .arstN  (arstN),
        .dacOut (dacOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // complementary pairs, powered, no calibration
    task automatic randomCode(output dacIn_t v);
        logic [31:0] r;
        v = '0;
        takeBits(`DAC_BIN_W, r);
        v.bin  = r[`DAC_BIN_W-1:0];
        v.binB = ~v.bin;
        takeBits(`DAC_THERM_W, r);
        v.therm  = r[`DAC_THERM_W-1:0];
        v.thermB = ~v.therm;
        v.pdb    = 1'b1;
    endtask

    // a masked pair ends up equal, so both switches open or both closed
    task automatic injectFaults(inout dacIn_t v);
        logic [31:0] a;
        logic [31:0] b;
        takeBits(`DAC_BIN_W, a);
        takeBits(`DAC_BIN_W, b);
        v.binB = ~v.bin ^ (a[`DAC_BIN_W-1:0] & b[`DAC_BIN_W-1:0]); // about one in four
        takeBits(`DAC_THERM_W, a);
        takeBits(`DAC_THERM_W, b);
        v.thermB = ~v.therm ^ (a[`DAC_THERM_W-1:0] & b[`DAC_THERM_W-1:0]);
    endtask

    task automatic applyVector(input dacIn_t v);
        @(posedge clk);
        dacIn <= v;
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        dacIn_t      v;
        logic [31:0] r;
        dacIn      = '0;
        arstN      = 1'b0;
        lfsr       = 32'hc994;
        endReached = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        repeat (3) applyVector('0); // unpowered, outputs stay zero

        randomCode(v);
        v.bin    = '0;
        v.binB   = '1;
        v.therm  = '0;
        v.thermB = '1;
        applyVector(v); // zero scale
        v.bin    = '1;
        v.binB   = '0;
        v.therm  = '1;
        v.thermB = '0;
        applyVector(v); // full scale
        repeat (NumSteer) begin
            randomCode(v);
            applyVector(v);
        end

        // every code, including 0 and the ones past the last cell
        for (int c = 0; c < 32; c++) begin
            repeat (NumCalRounds) begin
                randomCode(v);
                v.calSel = `DAC_CAL_W'(c);
                applyVector(v);
            end
        end

        repeat (NumFault) begin
            randomCode(v);
            injectFaults(v);
            takeBits(1 + `DAC_CAL_W, r);
            if (r[`DAC_CAL_W]) begin
                v.calSel = r[`DAC_CAL_W-1:0]; // calibrated cell masks its fault
            end
            applyVector(v);
        end

        repeat (NumPdRandom) begin
            randomCode(v);
            injectFaults(v);
            takeBits(2 + `DAC_CAL_W, r);
            v.calSel = r[`DAC_CAL_W-1:0];
            v.pdb    = |r[`DAC_CAL_W+1:`DAC_CAL_W]; // low one time in four
            applyVector(v);
        end

        // one code held while pdb drops and returns
        repeat (NumPdBlocks) begin
            randomCode(v);
            v.pdb = 1'b0;
            repeat (5) applyVector(v);
            v.pdb = 1'b1;
            repeat (5) applyVector(v);
        end

        repeat (5) @(posedge clk); // drain the pipeline
        endReached = 1'b1;
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    final begin
        if (!endReached && cycleCount < TimeoutCycles) begin
            $display("the run stopped before the last vector was checked");
            $display("FAIL: see errors above");
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/dacPkg.sv
design/steerDecoder.sv
design/currentCell.sv
design/outputCombiner.sv
design/currentSteeringDac.sv
dv/dac_props.sv
dv/dacChecker.sv
dv/dacTb.sv

//--- run.sh
#!/bin/sh
# build and run the DAC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dacTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VdacTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
